//--- hdl/ring_pkg.sv
/* Ring slot layout and host types for the 64-bit peripheral ring. Only one
   slot is ever in flight, so slots carry no tag or source id. */
package ring_pkg;

  // Width of one ring slot in bits
  localparam int RING_W = 64;

  // Byte address on the ring, word aligned by the low two bits
  typedef logic [19:0] ring_addr_t;

  // Request view of a slot, as injected by the master
  typedef struct packed {
    logic        valid;
    logic        resp;
    logic        wr;
    logic [3:0]  mask;
    logic [4:0]  spare;
    ring_addr_t  addr;
    logic [31:0] wdata;
  } ring_req_t;

  // Response view of a slot, as turned around by a node or the master
  typedef struct packed {
    logic        valid;
    logic        resp;
    logic        wr;
    logic        err;
    logic [7:0]  spare;
    ring_addr_t  addr;
    logic [31:0] rdata;
  } ring_rsp_t;

  // The resp bit sits at the same position in both views and picks the one that applies
  typedef union packed {
    ring_req_t req;
    ring_rsp_t rsp;
  } ring_slot_u;

  // One host command, sampled on the request strobe
  typedef struct packed {
    logic        wr;
    logic [3:0]  mask;
    ring_addr_t  addr;
    logic [31:0] wdata;
  } host_cmd_t;

  // Registers written by test software to report its progress
  typedef struct packed {
    logic [31:0] progress;
    logic [31:0] fail;
    logic [31:0] pass;
  } test_status_t;

  // True when the slot is a live request that falls inside the node's window
  function automatic logic ring_claims(ring_slot_u s, ring_addr_t mask, ring_addr_t base);
    return s.req.valid && !s.req.resp && ((s.req.addr & mask) == base);
  endfunction

  // Turns a claimed request into a good response carrying the given data
  function automatic ring_slot_u ring_reply(ring_slot_u s, logic [31:0] rdata);
    ring_slot_u r;
    r = {RING_W{1'b0}};
    r.rsp.valid = 1'b1;
    r.rsp.resp = 1'b1;
    r.rsp.wr = s.req.wr;
    r.rsp.addr = s.req.addr;
    r.rsp.rdata = rdata;
    return r;
  endfunction

  // Replaces only the bytes selected by the byte mask
  function automatic logic [31:0] byte_merge(logic [31:0] old, logic [31:0] wdata,
                                             logic [3:0] mask);
    logic [31:0] m;
    m = old;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) m[8*i +: 8] = wdata[8*i +: 8];
    end
    return m;
  endfunction

endpackage

//--- hdl/ring_master.sv
/* Single outstanding request only; a strobe while busy is dropped silently.
   Slots returning while idle are discarded, so stray traffic never reaches the host. */
`timescale 1ns/1ns

module ring_master import ring_pkg::*; (
  input  logic       clk_50,
  input  logic       arst_n,
  input  logic       host_req,
  input  host_cmd_t  host_cmd,
  output logic       host_busy,
  output logic       host_done,
  output ring_rsp_t  host_rsp,
  input  ring_slot_u slot_in,
  output ring_slot_u slot_out
);

  ring_req_t  inj;
  ring_rsp_t  ret;
  ring_slot_u rx_slot;

  // Request view built straight from the host command
  always_comb begin
    inj = '0;
    inj.valid = 1'b1;
    inj.resp = 1'b0;
    inj.wr = host_cmd.wr;
    inj.mask = host_cmd.mask;
    inj.addr = host_cmd.addr;
    inj.wdata = host_cmd.wdata;
  end

  // A slot that comes home still marked as a request was claimed by nobody
  always_comb begin
    ret = rx_slot.rsp;
    if (!rx_slot.req.resp) begin
      ret = '0;
      ret.valid = 1'b1;
      ret.resp = 1'b1;
      ret.wr = rx_slot.req.wr;
      ret.err = 1'b1;
      ret.addr = rx_slot.req.addr;
    end
  end

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      slot_out <= '0;
      rx_slot <= '0;
      host_busy <= 1'b0;
      host_done <= 1'b0;
      host_rsp <= '0;
    end else begin
      // The master never forwards what it receives, so the ring empties behind each slot
      slot_out <= '0;
      host_done <= 1'b0;
      // Returning slot is registered first and decoded a cycle later
      rx_slot <= slot_in;
      if (host_req && !host_busy) begin
        slot_out.req <= inj;
        host_busy <= 1'b1;
      end
      // Only the slot we injected can come back while busy
      if (host_busy && rx_slot.req.valid) begin
        host_rsp <= ret;
        host_done <= 1'b1;
        host_busy <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/ring_event_node.sv
/* Window holds two words: offset 0 sets and reads, offset 1 clears.
   Writes ignore the byte mask and only the low four data bits count. */
`timescale 1ns/1ns

module ring_event_node import ring_pkg::*; #(
  parameter ring_addr_t ADDR_MASK = 20'hFFFF8,
  parameter ring_addr_t ADDR_BASE = 20'hE0000
) (
  input  logic       clk_50,
  input  logic       arst_n,
  input  ring_slot_u slot_in,
  output ring_slot_u slot_out,
  output logic [3:0] event_pending
);

  logic        hit;
  ring_addr_t  ofs;
  logic [17:0] word;
  logic [3:0]  pend_next;
  logic [31:0] rdata;

  assign hit = ring_claims(slot_in, ADDR_MASK, ADDR_BASE);

  // Word offset inside the window, taken from the address bits the mask leaves free
  assign ofs = slot_in.req.addr & ~ADDR_MASK;
  assign word = ofs[19:2];

  always_comb begin
    pend_next = event_pending;
    rdata = '0;
    if (hit) begin
      case (word)
        18'd0: begin
          if (slot_in.req.wr) pend_next = event_pending | slot_in.req.wdata[3:0];
          rdata = {28'b0, pend_next};
        end
        18'd1: begin
          // Clear register reads back as zero, but a write echoes the new flags
          if (slot_in.req.wr) begin
            pend_next = event_pending & ~slot_in.req.wdata[3:0];
            rdata = {28'b0, pend_next};
          end
        end
        default: rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      slot_out <= '0;
      event_pending <= '0;
    end else begin
      event_pending <= pend_next;
      // Claimed requests turn into responses, everything else goes on unchanged
      if (hit) slot_out <= ring_reply(slot_in, rdata);
      else slot_out <= slot_in;
    end
  end

endmodule

//--- hdl/ring_testregs_node.sv
/* Progress, fail and pass registers at word offsets 0 to 2, byte maskable.
   Offset 3 reads zero and drops writes. */
`timescale 1ns/1ns

module ring_testregs_node import ring_pkg::*; #(
  parameter ring_addr_t ADDR_MASK = 20'hFFFF0,
  parameter ring_addr_t ADDR_BASE = 20'hFFFF0
) (
  input  logic         clk_50,
  input  logic         arst_n,
  input  ring_slot_u   slot_in,
  output ring_slot_u   slot_out,
  output test_status_t test_status
);

  logic         hit;
  ring_addr_t   ofs;
  logic [17:0]  word;
  logic         wr;
  test_status_t status_next;
  logic [31:0]  rdata;

  assign hit = ring_claims(slot_in, ADDR_MASK, ADDR_BASE);
  assign ofs = slot_in.req.addr & ~ADDR_MASK;
  assign word = ofs[19:2];
  assign wr = slot_in.req.wr;

  // Each register merges the write bytes and returns its updated value
  always_comb begin
    status_next = test_status;
    rdata = '0;
    if (hit) begin
      case (word)
        18'd0: begin
          if (wr) status_next.progress = byte_merge(test_status.progress,
                                                    slot_in.req.wdata, slot_in.req.mask);
          rdata = status_next.progress;
        end
        18'd1: begin
          if (wr) status_next.fail = byte_merge(test_status.fail,
                                                slot_in.req.wdata, slot_in.req.mask);
          rdata = status_next.fail;
        end
        18'd2: begin
          if (wr) status_next.pass = byte_merge(test_status.pass,
                                                slot_in.req.wdata, slot_in.req.mask);
          rdata = status_next.pass;
        end
        default: rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      slot_out <= '0;
      test_status <= '0;
    end else begin
      test_status <= status_next;
      if (hit) slot_out <= ring_reply(slot_in, rdata);
      else slot_out <= slot_in;
    end
  end

endmodule

//--- hdl/ring_sram_node.sv
/* Word memory with no reset, so contents are unknown until written.
   Addresses past SRAM_WORDS wrap around inside the window. */
`timescale 1ns/1ns

module ring_sram_node import ring_pkg::*; #(
  parameter ring_addr_t ADDR_MASK = 20'hF0000,
  parameter ring_addr_t ADDR_BASE = 20'h00000,
  parameter int SRAM_WORDS = 256
) (
  input  logic       clk_50,
  input  logic       arst_n,
  input  ring_slot_u slot_in,
  output ring_slot_u slot_out
);

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  logic [31:0]      mem [SRAM_WORDS];
  logic             hit;
  logic [17:0]      word;
  logic [IDX_W-1:0] idx;
  logic [31:0]      merged;
  logic [31:0]      rdata;

  assign hit = ring_claims(slot_in, ADDR_MASK, ADDR_BASE);

  // Index is the word address folded into the memory size
  assign word = slot_in.req.addr[19:2];
  assign idx = IDX_W'(word % SRAM_WORDS);

  // Write merges into the stored word; the response carries the result
  assign merged = byte_merge(mem[idx], slot_in.req.wdata, slot_in.req.mask);
  assign rdata = slot_in.req.wr ? merged : mem[idx];

  always_ff @(posedge clk_50) begin
    if (hit && slot_in.req.wr) begin
      mem[idx] <= merged;
    end
  end

  // Last stage before the master, so every slot leaving here heads home
  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      slot_out <= '0;
    end else begin
      if (hit) slot_out <= ring_reply(slot_in, rdata);
      else slot_out <= slot_in;
    end
  end

endmodule

//--- hdl/ring_top.sv
/* Closes master, event, test register and SRAM stages into one loop.
   Windows must not overlap, since the first matching stage claims the slot. */
`timescale 1ns/1ns

module ring_top import ring_pkg::*; #(
  parameter int SRAM_WORDS = 256,
  parameter ring_addr_t EVT_MASK = 20'hFFFF8,
  parameter ring_addr_t EVT_BASE = 20'hE0000,
  parameter ring_addr_t TREG_MASK = 20'hFFFF0,
  parameter ring_addr_t TREG_BASE = 20'hFFFF0,
  parameter ring_addr_t SRAM_MASK = 20'hF0000,
  parameter ring_addr_t SRAM_BASE = 20'h00000
) (
  input  logic         clk_50,
  input  logic         arst_n,
  input  logic         host_req,
  input  host_cmd_t    host_cmd,
  output logic         host_busy,
  output logic         host_done,
  output ring_rsp_t    host_rsp,
  output logic [3:0]   event_pending,
  output test_status_t test_status
);

  // Ring segments in flow order
  ring_slot_u slot_m2e;
  ring_slot_u slot_e2t;
  ring_slot_u slot_t2s;
  ring_slot_u slot_s2m;

  ring_master u_master (
    .clk_50(clk_50), .arst_n(arst_n),
    .host_req(host_req), .host_cmd(host_cmd),
    .host_busy(host_busy), .host_done(host_done), .host_rsp(host_rsp),
    .slot_in(slot_s2m), .slot_out(slot_m2e)
  );

  ring_event_node #(.ADDR_MASK(EVT_MASK), .ADDR_BASE(EVT_BASE)) u_event (
    .clk_50(clk_50), .arst_n(arst_n),
    .slot_in(slot_m2e), .slot_out(slot_e2t),
    .event_pending(event_pending)
  );

  ring_testregs_node #(.ADDR_MASK(TREG_MASK), .ADDR_BASE(TREG_BASE)) u_testregs (
    .clk_50(clk_50), .arst_n(arst_n),
    .slot_in(slot_e2t), .slot_out(slot_t2s),
    .test_status(test_status)
  );

  // SRAM feeds the master and so closes the ring
  ring_sram_node #(
    .ADDR_MASK(SRAM_MASK), .ADDR_BASE(SRAM_BASE), .SRAM_WORDS(SRAM_WORDS)
  ) u_sram (
    .clk_50(clk_50), .arst_n(arst_n),
    .slot_in(slot_t2s), .slot_out(slot_s2m)
  );

endmodule

//--- bench/tb_ring_top.sv
/* Run from the project root, since the golden file path is relative to it.
   SRAM words are written before they are read, because the SRAM has no reset. */
`timescale 1ns/1ns

module tb_ring_top import ring_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  // Worst case per command is a 7 cycle gap, 5 cycles of latency and 4 of handshake
  localparam int CMD_CYCLES = 7 + 5 + 4;
  localparam int MARGIN_CYCLES = 64;
  localparam int QUIET_CYCLES = 8;

  // One golden command line with its expected response
  typedef struct packed {
    host_cmd_t   cmd;
    logic [31:0] rdata;
    logic        err;
  } golden_cmd_t;

  // Expected status outputs from the closing STATUS line
  typedef struct packed {
    logic [3:0]   pending;
    test_status_t status;
  } golden_status_t;

  logic         clk_50;
  logic         arst_n;
  logic         host_req;
  host_cmd_t    host_cmd;
  logic         host_busy;
  logic         host_done;
  ring_rsp_t    host_rsp;
  logic [3:0]   event_pending;
  test_status_t test_status;

  golden_cmd_t    cmds[$];
  golden_status_t final_exp;
  logic           parse_ok;
  logic [31:0]    rng_state = 32'd19275;
  int             value_errors = 0;
  int             other_errors = 0;
  int             cmd_index = 0;
  int             cycles = 0;
  int             cycle_limit = RESET_CYCLES + MARGIN_CYCLES;

  ring_top u_dut (
    .clk_50(clk_50), .arst_n(arst_n),
    .host_req(host_req), .host_cmd(host_cmd),
    .host_busy(host_busy), .host_done(host_done), .host_rsp(host_rsp),
    .event_pending(event_pending), .test_status(test_status)
  );

  // 8 ns clock period
  initial clk_50 = 1'b0;
  always #4 clk_50 = ~clk_50;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t ns: command %0d, %s is %h, expected %h",
               $time, cmd_index, what, got, exp);
    end
  endtask

  // Upper bits of the LCG state are the better random ones
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Address windows of the memory map
  function automatic logic in_event_window(input ring_addr_t a);
    return (a & 20'hFFFF8) == 20'hE0000;
  endfunction

  function automatic logic in_treg_window(input ring_addr_t a);
    return (a & 20'hFFFF0) == 20'hFFFF0;
  endfunction

  task automatic end_run();
    $display("summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  task automatic read_golden();
    int               fd;
    int               code;
    logic [63:0]      tok;
    logic [8*128-1:0] rest;
    golden_cmd_t      g;
    logic [19:0]      a;
    logic [3:0]       m;
    logic [31:0]      wd;
    logic [31:0]      rd;
    logic             e;
    logic [3:0]       sp;
    logic [31:0]      sprog;
    logic [31:0]      sfail;
    logic [31:0]      spass;
    logic             done_reading;
    logic             got_status;
    parse_ok = 1'b0;
    fd = $fopen("bench/ring_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/ring_golden.txt from the current directory");
      other_errors++;
      return;
    end
    parse_ok = 1'b1;
    done_reading = 1'b0;
    got_status = 1'b0;
    while (!done_reading) begin
      tok = '0;
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        done_reading = 1'b1;
      end else if (tok == 64'("#")) begin
        // Comment line, skip the rest of it
        code = $fgets(rest, fd);
      end else if (tok == 64'("W") || tok == 64'("R")) begin
        code = $fscanf(fd, "%h %h %h %h %h", a, m, wd, rd, e);
        if (code != 5) begin
          $display("golden file command %0d is malformed", cmds.size() + 1);
          parse_ok = 1'b0;
          done_reading = 1'b1;
        end else begin
          g.cmd.wr = (tok == 64'("W"));
          g.cmd.mask = m;
          g.cmd.addr = a;
          g.cmd.wdata = wd;
          g.rdata = rd;
          g.err = e;
          cmds.push_back(g);
        end
      end else if (tok == 64'("STATUS")) begin
        code = $fscanf(fd, "%h %h %h %h", sp, sprog, sfail, spass);
        if (code != 4) begin
          $display("golden file STATUS line is malformed");
          parse_ok = 1'b0;
        end else begin
          final_exp.pending = sp;
          final_exp.status.progress = sprog;
          final_exp.status.fail = sfail;
          final_exp.status.pass = spass;
          got_status = 1'b1;
        end
        done_reading = 1'b1;
      end else begin
        $display("golden file has an unknown command word after command %0d", cmds.size());
        parse_ok = 1'b0;
        done_reading = 1'b1;
      end
    end
    $fclose(fd);
    if (parse_ok && !got_status) begin
      $display("golden file ends without a STATUS line");
      parse_ok = 1'b0;
    end
    if (!parse_ok) other_errors++;
  endtask

  task automatic run_command(input golden_cmd_t g);
    int        lat;
    int        gap;
    host_cmd_t cmd;
    host_cmd_t junk;
    // A read carries inverted data under a full mask, so a read taken as a write shows up
    cmd = g.cmd;
    if (!cmd.wr) begin
      cmd.mask = 4'hf;
      cmd.wdata = ~g.rdata;
    end
    // Write that would set every event flag if the busy master took it
    junk = '0;
    junk.wr = 1'b1;
    junk.mask = 4'hf;
    junk.addr = 20'hE0000;
    junk.wdata = 32'h0000000f;
    while (host_busy) @(negedge clk_50);
    host_cmd = cmd;
    host_req = 1'b1;
    @(negedge clk_50);
    host_req = 1'b0;
    check_value("host_busy after strobe", 64'(host_busy), 64'd1);
    lat = 0;
    while (!host_done) begin
      @(negedge clk_50);
      lat++;
      // One strobe lands mid-flight and must be ignored
      host_req = (lat == 1);
      host_cmd = (lat == 1) ? junk : cmd;
    end
    host_req = 1'b0;
    host_cmd = '0;
    check_value("done latency", 64'(lat), 64'd5);
    check_value("rsp valid", 64'(host_rsp.valid), 64'd1);
    check_value("rsp resp", 64'(host_rsp.resp), 64'd1);
    check_value("rsp wr", 64'(host_rsp.wr), 64'(g.cmd.wr));
    check_value("rsp err", 64'(host_rsp.err), 64'(g.err));
    check_value("rsp addr", 64'(host_rsp.addr), 64'(g.cmd.addr));
    check_value("rsp rdata", 64'(host_rsp.rdata), 64'(g.rdata));
    // A write echoes the new register value, so the status outputs must match it
    if (g.cmd.wr && in_event_window(g.cmd.addr))
      check_value("event_pending", 64'(event_pending), 64'(g.rdata[3:0]));
    if (g.cmd.wr && in_treg_window(g.cmd.addr)) begin
      case (g.cmd.addr[3:2])
        2'd0: check_value("progress", 64'(test_status.progress), 64'(g.rdata));
        2'd1: check_value("fail", 64'(test_status.fail), 64'(g.rdata));
        2'd2: check_value("pass", 64'(test_status.pass), 64'(g.rdata));
        default: ;
      endcase
    end
    @(negedge clk_50);
    check_value("host_done pulse width", 64'(host_done), 64'd0);
    check_value("host_busy after done", 64'(host_busy), 64'd0);
    rng_state = lcg_next(rng_state);
    gap = int'(rng_state[18:16]);
    repeat (gap) begin
      @(negedge clk_50);
      check_value("host_done while idle", 64'(host_done), 64'd0);
    end
  endtask

  // Ends the run if the DUT stops answering
  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk_50);
      cycles++;
    end
    $display("timeout: the test did not finish within %0d clock cycles", cycle_limit);
    other_errors++;
    end_run();
  end

  initial begin
    arst_n = 1'b0;
    host_req = 1'b0;
    host_cmd = '0;
    read_golden();
    cycle_limit = RESET_CYCLES + cmds.size() * CMD_CYCLES + MARGIN_CYCLES;
    if (!parse_ok) begin
      end_run();
    end else begin
      repeat (RESET_CYCLES) @(negedge clk_50);
      arst_n = 1'b1;
      @(negedge clk_50);
      check_value("host_busy after reset", 64'(host_busy), 64'd0);
      check_value("host_done after reset", 64'(host_done), 64'd0);
      check_value("host_rsp after reset", 64'(host_rsp), 64'd0);
      check_value("event_pending after reset", 64'(event_pending), 64'd0);
      check_value("progress after reset", 64'(test_status.progress), 64'd0);
      check_value("fail after reset", 64'(test_status.fail), 64'd0);
      check_value("pass after reset", 64'(test_status.pass), 64'd0);
      foreach (cmds[i]) begin
        cmd_index = i + 1;
        run_command(cmds[i]);
      end
      cmd_index = 0;
      // No late or extra done after the last command
      repeat (QUIET_CYCLES) begin
        @(negedge clk_50);
        check_value("host_done after last command", 64'(host_done), 64'd0);
      end
      check_value("final event_pending", 64'(event_pending), 64'(final_exp.pending));
      check_value("final progress", 64'(test_status.progress),
                  64'(final_exp.status.progress));
      check_value("final fail", 64'(test_status.fail), 64'(final_exp.status.fail));
      check_value("final pass", 64'(test_status.pass), 64'(final_exp.status.pass));
      end_run();
    end
  end

endmodule

//--- bench/ring_golden.txt
# op addr mask wdata exp_rdata exp_err, all hex; W writes, R reads
# STATUS event_pending progress fail pass closes the list
W 00000 f 12345678 12345678 0
R 00000 0 00000000 12345678 0
W 00004 f a5a5a5a5 a5a5a5a5 0
W 00004 3 0000beef a5a5beef 0
R 00004 0 00000000 a5a5beef 0
W 00008 f 00000000 00000000 0
W 00008 c cafe0000 cafe0000 0
R 00008 0 00000000 cafe0000 0
W 00010 f ffffffff ffffffff 0
W 00010 a 00990077 00ff00ff 0
R 00010 0 00000000 00ff00ff 0
W 003fc f deadbeef deadbeef 0
R 00400 0 00000000 12345678 0
R 003fc 0 00000000 deadbeef 0
R e0000 0 00000000 00000000 0
W e0000 f 00000005 00000005 0
W e0000 f 00000002 00000007 0
R e0000 0 00000000 00000007 0
W e0004 f 00000004 00000003 0
R e0004 0 00000000 00000000 0
W e0000 0 fffffff8 0000000b 0
R e0000 0 00000000 0000000b 0
W ffff0 f 00000001 00000001 0
W ffff4 f 00000000 00000000 0
W ffff0 2 00000300 00000301 0
R ffff0 0 00000000 00000301 0
W ffff8 f 600d600d 600d600d 0
W ffff8 1 000000aa 600d60aa 0
R ffff8 0 00000000 600d60aa 0
W ffff4 0 ffffffff 00000000 0
R ffffc 0 00000000 00000000 0
W ffffc f 12345678 00000000 0
R 80000 0 00000000 00000000 1
W 80000 f 12345678 00000000 1
R e0008 0 00000000 00000000 1
R 10000 0 00000000 00000000 1
STATUS b 00000301 00000000 600d60aa

//--- filelist.f
hdl/ring_pkg.sv
hdl/ring_master.sv
hdl/ring_event_node.sv
hdl/ring_testregs_node.sv
hdl/ring_sram_node.sv
hdl/ring_top.sv
bench/tb_ring_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ring testbench with Verilator, runs it and checks the log.
# Run from any directory; everything happens in the project root.

set -u

cd "$(dirname "$0")" || { echo "cannot enter the project root"; exit 1; }

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_ring_top

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator is not on the PATH"
  exit 1
fi

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
  --top-module "$TOP" -f filelist.f --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
exit 1
